//--- hw/icache_pkg.sv
// Instruction cache tag section package
// Holds the address geometry and the command opcode encoding shared by the RTL

package icache_pkg;

	// ========================================
	// Address geometry
	// ========================================

	// Width of a physical code address in bits
	localparam int addr_w = 32;

	// A line holds 128 bytes, so the low seven address bits select a byte in the line
	// These bits never reach the tag or index logic
	localparam int off_w = 7;

	// The index and tag widths depend on the line count, which is a module parameter
	// Each module derives them locally from lines and the two constants above

	// ========================================
	// Command opcodes
	// ========================================

	// Lookup compares the tag of the address against every way of its set
	// Fill installs the tag in the victim way chosen by the controller
	// Invalidate line clears every way of one set
	// Invalidate all clears the whole valid array
	typedef enum logic [1:0] {
		op_lookup   = 2'd0,
		op_fill     = 2'd1,
		op_inv_line = 2'd2,
		op_inv_all  = 2'd3
	} ic_op_e;

	// Only lookups produce a response
	// Fills and invalidates complete silently two cycles after their strobe

endpackage

//--- hw/ic_valid.sv
// Instruction cache valid array
// One valid bit per way and line, set on fill, cleared on line or full invalidation

module ic_valid #(
	parameter int lines = 128,
	parameter int ways  = 4
) (
	input  logic                                clk,
	input  logic                                rst,
	input  logic                                req_fill,
	input  logic                                req_inv_line,
	input  logic                                req_inv_all,
	input  logic [$clog2(lines)-1:0]            req_index,
	input  logic [((ways > 1) ? $clog2(ways) : 1)-1:0] fill_way,
	output logic [ways-1:0]                     way_valid
);

	localparam int way_w = (ways > 1) ? $clog2(ways) : 1;

	// One bit vector per way, indexed by line
	logic [lines-1:0] valid_bits [ways];

	// ========================================
	// Valid bit update
	// ========================================

	// A fill wins over invalidation, although the controller never raises both
	// An invalidate line clears the addressed set in every way at once
	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			for (int w = 0; w < ways; w++) begin
				valid_bits[w] <= '0;
			end
		end else if (req_fill) begin
			valid_bits[fill_way][req_index] <= 1'b1;
		end else if (req_inv_line) begin
			for (int w = 0; w < ways; w++) begin
				valid_bits[w][req_index] <= 1'b0;
			end
		end else if (req_inv_all) begin
			for (int w = 0; w < ways; w++) begin
				valid_bits[w] <= '0;
			end
		end
	end

	// Read the set named by the registered index
	// The controller uses this vector for victim choice, the tag ways for qualifying hits
	always_comb begin
		for (int w = 0; w < ways; w++) begin
			way_valid[w] = valid_bits[w][req_index];
		end
	end

	// ========================================
	// Assertions
	// ========================================

	// The controller must never name a way that does not exist
	// One extra bit holds the way count itself when ways is a power of two
	property p_fill_way_range;
		@(posedge clk) disable iff (rst)
		req_fill |-> ({1'b0, fill_way} < (way_w + 1)'(ways));
	endproperty
	a_fill_way_range: assert property (p_fill_way_range)
		else $error("ic_valid: fill to way %0d beyond %0d ways", fill_way, ways);

	// After an invalidate all, whatever set is addressed next must read as empty
	property p_inv_all_clears;
		@(posedge clk) disable iff (rst)
		req_inv_all |=> (way_valid == '0);
	endproperty
	a_inv_all_clears: assert property (p_inv_all_clears)
		else $error("ic_valid: set still valid after invalidate all");

endmodule

//--- hw/ic_tag_way.sv
// Instruction cache tag way
// Stores one tag per line for a single way and compares it against the lookup address

module ic_tag_way #(
	parameter int lines = 128
) (
	input  logic                     clk,
	input  logic                     req_lookup,
	input  logic                     req_fill,
	input  logic                     fill_sel,
	input  logic [$clog2(lines)-1:0] req_index,
	input  logic [icache_pkg::addr_w-icache_pkg::off_w-$clog2(lines)-1:0] req_tag,
	input  logic                     line_valid,
	output logic                     hit
);

	localparam int idx_w = $clog2(lines);
	localparam int tag_w = icache_pkg::addr_w - icache_pkg::off_w - idx_w;

	// Tag storage for this way, one entry per line
	// Contents are meaningless until the matching valid bit is set
	logic [tag_w-1:0] tag_mem [lines];

	// The tag read out at the registered index
	logic [tag_w-1:0] stored_tag;

	// ========================================
	// Tag write
	// ========================================

	// Only the victim way takes the fill
	// The write lands at the same edge that sets the valid bit
	always_ff @(posedge clk) begin
		if (req_fill && fill_sel) begin
			tag_mem[req_index] <= req_tag;
		end
	end

	// ========================================
	// Tag compare
	// ========================================

	assign stored_tag = tag_mem[req_index];

	// A hit needs a live lookup, a valid line and an equal tag
	// Gating with req_lookup keeps fills and invalidates from showing a hit
	assign hit = req_lookup && line_valid && (stored_tag == req_tag);

endmodule

//--- hw/ic_req_ctrl.sv
// Instruction cache request controller
// Registers each command, splits its address and picks the victim way for fills

module ic_req_ctrl #(
	parameter int lines = 128,
	parameter int ways  = 4
) (
	input  logic                     clk,
	input  logic                     rst,
	input  logic                     cmd_valid,
	input  icache_pkg::ic_op_e       cmd_op,
	input  logic [icache_pkg::addr_w-1:0] cmd_addr,
	input  logic [ways-1:0]          set_valid,
	output logic                     req_lookup,
	output logic                     req_fill,
	output logic                     req_inv_line,
	output logic                     req_inv_all,
	output logic [$clog2(lines)-1:0] req_index,
	output logic [icache_pkg::addr_w-icache_pkg::off_w-$clog2(lines)-1:0] req_tag,
	output logic [((ways > 1) ? $clog2(ways) : 1)-1:0] fill_way
);

	localparam int idx_w = $clog2(lines);
	localparam int tag_w = icache_pkg::addr_w - icache_pkg::off_w - idx_w;
	localparam int way_w = (ways > 1) ? $clog2(ways) : 1;

	// Round-robin replacement pointer shared by every set
	logic [way_w-1:0] rr_ptr;

	// Lowest way of the set that holds no valid line
	logic [way_w-1:0] first_free;
	logic             set_full;

	// ========================================
	// Command register
	// ========================================

	// Decode the opcode into one-hot strobes, each lasting a single cycle
	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			req_lookup   <= 1'b0;
			req_fill     <= 1'b0;
			req_inv_line <= 1'b0;
			req_inv_all  <= 1'b0;
		end else begin
			req_lookup   <= cmd_valid && (cmd_op == icache_pkg::op_lookup);
			req_fill     <= cmd_valid && (cmd_op == icache_pkg::op_fill);
			req_inv_line <= cmd_valid && (cmd_op == icache_pkg::op_inv_line);
			req_inv_all  <= cmd_valid && (cmd_op == icache_pkg::op_inv_all);
		end
	end

	// The byte offset is dropped, the index picks the set and the rest is the tag
	always_ff @(posedge clk) begin
		if (cmd_valid) begin
			req_index <= cmd_addr[icache_pkg::off_w +: idx_w];
			req_tag   <= cmd_addr[icache_pkg::addr_w-1 -: tag_w];
		end
	end

	// ========================================
	// Victim selection
	// ========================================

	// Scan from the top down so the lowest invalid way is the one left standing
	always_comb begin
		first_free = '0;
		for (int w = ways - 1; w >= 0; w--) begin
			if (!set_valid[w]) begin
				first_free = way_w'(w);
			end
		end
	end

	assign set_full = &set_valid;

	// A set with a hole is refilled in place, a full set evicts at the pointer
	assign fill_way = set_full ? rr_ptr : first_free;

	// The pointer moves only when a valid line is actually replaced
	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			rr_ptr <= '0;
		end else if (req_fill && set_full) begin
			if (rr_ptr == way_w'(ways - 1)) begin
				rr_ptr <= '0;
			end else begin
				rr_ptr <= rr_ptr + 1'b1;
			end
		end
	end

	// ========================================
	// Assertions
	// ========================================

	a_one_strobe: assert property (@(posedge clk) disable iff (rst)
		$onehot0({req_lookup, req_fill, req_inv_line, req_inv_all}))
		else $error("ic_req_ctrl: more than one command strobe active");

	a_ptr_range: assert property (@(posedge clk) disable iff (rst)
		rr_ptr <= way_w'(ways - 1))
		else $error("ic_req_ctrl: replacement pointer %0d out of range", rr_ptr);

endmodule

//--- hw/ic_hit_merge.sv
// Instruction cache hit merger
// Encodes the per-way hit vector and registers the lookup response

module ic_hit_merge #(
	parameter int ways = 4
) (
	input  logic                     clk,
	input  logic                     rst,
	input  logic                     req_lookup,
	input  logic [ways-1:0]          way_hit,
	output logic                     resp_valid,
	output logic                     resp_hit,
	output logic [((ways > 1) ? $clog2(ways) : 1)-1:0] resp_way
);

	localparam int way_w = (ways > 1) ? $clog2(ways) : 1;

	// Binary number of the hitting way
	logic [way_w-1:0] hit_enc;

	// ========================================
	// Hit encoding
	// ========================================

	// OR the index of each set bit together
	// With a one-hot vector this gives the hitting way, with none it gives zero
	always_comb begin
		hit_enc = '0;
		for (int w = 0; w < ways; w++) begin
			if (way_hit[w]) begin
				hit_enc = hit_enc | way_w'(w);
			end
		end
	end

	// ========================================
	// Response register
	// ========================================

	// The strobe follows every lookup by exactly one cycle
	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			resp_valid <= 1'b0;
			resp_hit   <= 1'b0;
		end else begin
			resp_valid <= req_lookup;
			if (req_lookup) begin
				resp_hit <= |way_hit;
			end
		end
	end

	// The way number only means something when resp_hit is set
	always_ff @(posedge clk) begin
		if (req_lookup) begin
			resp_way <= hit_enc;
		end
	end

	// Two ways holding the same valid tag would mean the victim logic went wrong
	a_single_hit: assert property (@(posedge clk) disable iff (rst)
		$onehot0(way_hit))
		else $error("ic_hit_merge: several ways hit at once (%b)", way_hit);

endmodule

//--- hw/ic_tag_top.sv
// Instruction cache tag and valid section
// Connects the request controller, the tag ways, the valid array and the hit merger

module ic_tag_top #(
	parameter int lines = 128,
	parameter int ways  = 4
) (
	input  logic                     clk,
	input  logic                     rst,
	input  logic                     cmd_valid,
	input  icache_pkg::ic_op_e       cmd_op,
	input  logic [icache_pkg::addr_w-1:0] cmd_addr,
	output logic                     resp_valid,
	output logic                     resp_hit,
	output logic [((ways > 1) ? $clog2(ways) : 1)-1:0] resp_way
);

	localparam int idx_w = $clog2(lines);
	localparam int tag_w = icache_pkg::addr_w - icache_pkg::off_w - idx_w;
	localparam int way_w = (ways > 1) ? $clog2(ways) : 1;

	// Registered command from the controller
	logic             req_lookup;
	logic             req_fill;
	logic             req_inv_line;
	logic             req_inv_all;
	logic [idx_w-1:0] req_index;
	logic [tag_w-1:0] req_tag;
	logic [way_w-1:0] fill_way;

	// Valid bits of the addressed set and the per-way compare results
	logic [ways-1:0]  way_valid;
	logic [ways-1:0]  way_hit;

	ic_req_ctrl #(.lines(lines), .ways(ways)) u_req_ctrl (
		.clk          (clk),
		.rst          (rst),
		.cmd_valid    (cmd_valid),
		.cmd_op       (cmd_op),
		.cmd_addr     (cmd_addr),
		.set_valid    (way_valid),
		.req_lookup   (req_lookup),
		.req_fill     (req_fill),
		.req_inv_line (req_inv_line),
		.req_inv_all  (req_inv_all),
		.req_index    (req_index),
		.req_tag      (req_tag),
		.fill_way     (fill_way)
	);

	// One tag store per way, each selected for fills by decoding fill_way
	for (genvar g = 0; g < ways; g++) begin : g_way
		ic_tag_way #(.lines(lines)) u_tag_way (
			.clk        (clk),
			.req_lookup (req_lookup),
			.req_fill   (req_fill),
			.fill_sel   (fill_way == way_w'(g)),
			.req_index  (req_index),
			.req_tag    (req_tag),
			.line_valid (way_valid[g]),
			.hit        (way_hit[g])
		);
	end

	ic_valid #(.lines(lines), .ways(ways)) u_valid (
		.clk          (clk),
		.rst          (rst),
		.req_fill     (req_fill),
		.req_inv_line (req_inv_line),
		.req_inv_all  (req_inv_all),
		.req_index    (req_index),
		.fill_way     (fill_way),
		.way_valid    (way_valid)
	);

	ic_hit_merge #(.ways(ways)) u_hit_merge (
		.clk        (clk),
		.rst        (rst),
		.req_lookup (req_lookup),
		.way_hit    (way_hit),
		.resp_valid (resp_valid),
		.resp_hit   (resp_hit),
		.resp_way   (resp_way)
	);

endmodule

//--- bench/tb_ic_tag.sv
// Testbench for the instruction cache tag and valid section
// Drives lookups, fills and invalidates and checks responses against a reference model

module tb_ic_tag;

	localparam int lines  = 128;
	localparam int ways   = 4;
	localparam int idx_w  = $clog2(lines);
	localparam int tag_w  = icache_pkg::addr_w - icache_pkg::off_w - idx_w;
	localparam int way_w  = $clog2(ways);
	localparam int n_rand = 200;
	// Directed tests issue 52 commands in total, the random mix adds the rest
	localparam int n_cmds = 52 + n_rand;

	logic                          clk;
	logic                          rst;
	logic                          cmd_valid;
	icache_pkg::ic_op_e            cmd_op;
	logic [icache_pkg::addr_w-1:0] cmd_addr;
	logic                          resp_valid;
	logic                          resp_hit;
	logic [way_w-1:0]              resp_way;

	// Reference model state
	logic [tag_w-1:0] m_tag [ways][lines];
	bit               m_valid [ways][lines];
	int               m_rr;

	// Pending lookup responses, each with the cycle it is due in
	int               due_q [$];
	bit               hit_q [$];
	logic [way_w-1:0] way_q [$];

	// Expected response for the current cycle, changed only on the falling edge
	logic             exp_valid;
	logic             exp_hit;
	logic [way_w-1:0] exp_way;
	int               cycle;
	int               value_errs;
	int               missing_errs;
	int               extra_errs;

	ic_tag_top #(.lines(lines), .ways(ways)) UUT (
		.clk        (clk),
		.rst        (rst),
		.cmd_valid  (cmd_valid),
		.cmd_op     (cmd_op),
		.cmd_addr   (cmd_addr),
		.resp_valid (resp_valid),
		.resp_hit   (resp_hit),
		.resp_way   (resp_way)
	);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	// ========================================
	// Reference model
	// ========================================

	function automatic bit model_hit(int idx, logic [tag_w-1:0] tag, output int way);
		bit hit;
		hit = 1'b0;
		way = 0;
		for (int w = 0; w < ways; w++) begin
			if (m_valid[w][idx] && m_tag[w][idx] == tag) begin
				hit = 1'b1;
				way = w;
			end
		end
		return hit;
	endfunction

	function automatic bit model_full(int idx);
		bit full;
		full = 1'b1;
		for (int w = 0; w < ways; w++) begin
			full = full & m_valid[w][idx];
		end
		return full;
	endfunction

	// Lowest empty way, or the shared pointer once the set is full
	function automatic int model_victim(int idx);
		int v;
		v = m_rr;
		for (int w = ways - 1; w >= 0; w--) begin
			if (!m_valid[w][idx]) begin
				v = w;
			end
		end
		return v;
	endfunction

	// Random byte offset, so the offset bits are shown to be ignored
	function automatic logic [icache_pkg::addr_w-1:0] make_addr(int tag, int idx);
		logic [icache_pkg::addr_w-1:0] a;
		a = $urandom;
		a[icache_pkg::off_w +: idx_w] = idx_w'(idx);
		a[icache_pkg::addr_w-1 -: tag_w] = tag_w'(tag);
		return a;
	endfunction

	// ========================================
	// Stimulus tasks
	// ========================================

	// Every stimulus step starts here and loads the expectation for this cycle
	task automatic tick();
		@(negedge clk);
		cycle++;
		if (due_q.size() > 0 && due_q[0] == cycle) begin
			exp_valid = 1'b1;
			exp_hit   = hit_q.pop_front();
			exp_way   = way_q.pop_front();
			void'(due_q.pop_front());
		end else begin
			exp_valid = 1'b0;
		end
	endtask

	task automatic idle();
		tick();
		cmd_valid = 1'b0;
	endtask

	// The model changes state in issue order, which matches the DUT pipeline
	task automatic issue(icache_pkg::ic_op_e op, logic [icache_pkg::addr_w-1:0] addr);
		int               idx;
		logic [tag_w-1:0] tag;
		int               way;
		bit               hit;
		tick();
		cmd_valid = 1'b1;
		cmd_op    = op;
		cmd_addr  = addr;
		idx = addr[icache_pkg::off_w +: idx_w];
		tag = addr[icache_pkg::addr_w-1 -: tag_w];
		case (op)
			icache_pkg::op_lookup: begin
				hit = model_hit(idx, tag, way);
				due_q.push_back(cycle + 2);
				hit_q.push_back(hit);
				way_q.push_back(way_w'(way));
			end
			icache_pkg::op_fill: begin
				way = model_victim(idx);
				if (model_full(idx)) begin
					m_rr = (m_rr + 1) % ways;
				end
				m_tag[way][idx]   = tag;
				m_valid[way][idx] = 1'b1;
			end
			icache_pkg::op_inv_line: begin
				for (int w = 0; w < ways; w++) begin
					m_valid[w][idx] = 1'b0;
				end
			end
			default: begin
				for (int w = 0; w < ways; w++) begin
					for (int i = 0; i < lines; i++) begin
						m_valid[w][i] = 1'b0;
					end
				end
			end
		endcase
	endtask

	// ========================================
	// Response checks
	// ========================================

	a_resp_present: assert property (@(posedge clk) disable iff (rst)
		exp_valid |-> resp_valid)
		else begin
			missing_errs++;
			$display("Lookup response missing at time %0t", $time);
		end

	a_resp_extra: assert property (@(posedge clk) disable iff (rst)
		!exp_valid |-> !resp_valid)
		else begin
			extra_errs++;
			$display("Response strobe with no lookup pending at time %0t", $time);
		end

	a_hit_flag: assert property (@(posedge clk) disable iff (rst)
		exp_valid |-> resp_hit == exp_hit)
		else begin
			value_errs++;
			$display("FAIL %0t: hit flag %0b, expected %0b", $time, $sampled(resp_hit), exp_hit);
		end

	a_hit_way: assert property (@(posedge clk) disable iff (rst)
		(exp_valid && exp_hit) |-> resp_way == exp_way)
		else begin
			value_errs++;
			$display("FAIL %0t: hit way %0d, expected %0d", $time, $sampled(resp_way), exp_way);
		end

	// ========================================
	// Test sequence
	// ========================================

	initial begin
		int               r;
		int               way;
		int               idx;
		int               tag;
		logic [tag_w-1:0] old_tag;
		icache_pkg::ic_op_e op;
		void'($urandom(32'hb110_b0c4));
		rst          = 1'b1;
		cmd_valid    = 1'b0;
		cmd_op       = icache_pkg::op_lookup;
		cmd_addr     = '0;
		exp_valid    = 1'b0;
		exp_hit      = 1'b0;
		exp_way      = '0;
		cycle        = 0;
		m_rr         = 0;
		value_errs   = 0;
		missing_errs = 0;
		extra_errs   = 0;
		repeat (5) idle();
		rst = 1'b0;

		// Empty cache, isolated lookups and then back to back ones
		for (int i = 0; i < 4; i++) begin
			issue(icache_pkg::op_lookup, $urandom);
			idle();
		end
		for (int i = 0; i < 4; i++) begin
			issue(icache_pkg::op_lookup, $urandom);
		end

		// Four fills into set 5, each looked up on the very next cycle
		for (int i = 0; i < 4; i++) begin
			issue(icache_pkg::op_fill, make_addr(10 + i, 5));
			issue(icache_pkg::op_lookup, make_addr(10 + i, 5));
		end

		// Full set, so every fill evicts the way under the pointer
		for (int i = 0; i < 5; i++) begin
			old_tag = m_tag[model_victim(5)][5];
			issue(icache_pkg::op_fill, make_addr(14 + i, 5));
			issue(icache_pkg::op_lookup, make_addr(old_tag, 5));
			issue(icache_pkg::op_lookup, make_addr(14 + i, 5));
		end

		// Clearing set 5 must leave set 9 alone
		issue(icache_pkg::op_fill, make_addr(40, 9));
		issue(icache_pkg::op_fill, make_addr(41, 9));
		issue(icache_pkg::op_inv_line, make_addr(0, 5));
		for (int i = 0; i < 4; i++) begin
			issue(icache_pkg::op_lookup, make_addr(15 + i, 5));
		end
		issue(icache_pkg::op_lookup, make_addr(40, 9));
		issue(icache_pkg::op_lookup, make_addr(41, 9));
		issue(icache_pkg::op_fill, make_addr(20, 5));
		issue(icache_pkg::op_lookup, make_addr(20, 5));

		// After a full clear the fifth fill shows whether the pointer moved
		issue(icache_pkg::op_inv_all, '0);
		issue(icache_pkg::op_lookup, make_addr(40, 9));
		issue(icache_pkg::op_lookup, make_addr(41, 9));
		issue(icache_pkg::op_lookup, make_addr(20, 5));
		for (int i = 0; i < 5; i++) begin
			issue(icache_pkg::op_fill, make_addr(30 + i, 5));
		end
		issue(icache_pkg::op_lookup, make_addr(34, 5));

		// Random traffic over few sets and tags so hits and evictions are frequent
		for (int i = 0; i < n_rand; i++) begin
			r   = $urandom % 16;
			idx = $urandom % 4;
			tag = $urandom % 8;
			if (r < 8) begin
				op = icache_pkg::op_lookup;
			end else if (r < 13) begin
				op = icache_pkg::op_fill;
			end else if (r < 15) begin
				op = icache_pkg::op_inv_line;
			end else begin
				op = icache_pkg::op_inv_all;
			end
			// A tag already in the set is looked up rather than filled twice
			if (op == icache_pkg::op_fill && model_hit(idx, tag_w'(tag), way)) begin
				op = icache_pkg::op_lookup;
			end
			issue(op, make_addr(tag, idx));
		end
		repeat (4) idle();

		if (due_q.size() > 0) begin
			missing_errs += due_q.size();
			$display("%0d lookup responses never arrived", due_q.size());
		end
		$display("Errors: %0d wrong values, %0d missing responses, %0d extra responses",
			value_errs, missing_errs, extra_errs);
		if (value_errs + missing_errs + extra_errs == 0) begin
			$display("PASS: all tests");
		end else begin
			$display("FAIL: see errors above");
		end
		$finish;
	end

	// Ends a stuck run, with room for reset and the final drain
	initial begin
		#((n_cmds + 20) * 10);
		$display("Watchdog timeout, the test sequence did not finish in time");
		$display("FAIL: see errors above");
		$finish;
	end

endmodule

//--- project.f
hw/icache_pkg.sv
hw/ic_valid.sv
hw/ic_tag_way.sv
hw/ic_req_ctrl.sv
hw/ic_hit_merge.sv
hw/ic_tag_top.sv
bench/tb_ic_tag.sv

//--- Bender.yml
package:
  name: ic_tag

sources:
  - hw/icache_pkg.sv
  - hw/ic_valid.sv
  - hw/ic_tag_way.sv
  - hw/ic_req_ctrl.sv
  - hw/ic_hit_merge.sv
  - hw/ic_tag_top.sv
  - target: test
    files:
      - bench/tb_ic_tag.sv
